/* rtl/axi_pkg.sv */
package axi_pkg;

   // Fixed 32-bit data path
   typedef logic [31:0] axi_addr_t;
   typedef logic [31:0] axi_data_t;
   typedef logic [3:0]  axi_strb_t;
   typedef logic [7:0]  axi_len_t;   // Beats minus one
   typedef logic [1:0]  axi_resp_t;

   localparam logic [2:0] AXI_SIZE_4B = 3'b010;
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

   // Bursts may not cross a 4 KB page
   localparam int AXI_BOUNDARY_W = 12;

endpackage

/* rtl/xfer_pkg.sv */
package xfer_pkg;

   // Client transfer
   typedef logic [7:0] byte_len_t;   // 1 to 255 bytes
   typedef logic [1:0] byte_off_t;

   // Register file
   typedef logic [1:0]  cfg_addr_t;
   typedef logic [15:0] cfg_data_t;

   localparam cfg_addr_t CFG_BURST_LIMIT = 2'd0;
   localparam cfg_addr_t CFG_ATTR = 2'd1;         // [3:0] cache, [6:4] prot
   localparam cfg_addr_t CFG_ERR_COUNT = 2'd2;    // Write clears
   localparam cfg_addr_t CFG_DONE_COUNT = 2'd3;   // Write clears

   // Cache 2, prot 2
   localparam cfg_data_t CFG_ATTR_RESET = 16'h0022;

endpackage

/* rtl/burst_if.sv */
`timescale 1ns/1ps

interface burst_if;

   logic start;   // New transfer
   logic next;    // Advance to following burst

   axi_pkg::axi_addr_t addr;
   axi_pkg::axi_len_t  len;
   axi_pkg::axi_strb_t first_strb;
   axi_pkg::axi_strb_t last_strb;
   logic               last_burst;

   modport planner (
      input  start, next,
      output addr, len, first_strb, last_strb, last_burst
   );

   modport engine (
      output start, next,
      input  addr, len, first_strb, last_strb, last_burst
   );

endinterface

/* rtl/burst_planner.sv */
`timescale 1ns/1ps

module burst_planner #(
   parameter int MAX_BEATS_LOG2 = 4
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  axi_pkg::axi_addr_t  addr_i,
   input  xfer_pkg::byte_len_t len_i,
   input  axi_pkg::axi_len_t   limit_i,   // Beat count, 0 means ceiling
   burst_if.planner            b
);

   localparam logic [10:0] MAX_BEATS = 11'(1 << MAX_BEATS_LOG2);
   localparam logic [10:0] PAGE_BEATS = 11'(1 << (axi_pkg::AXI_BOUNDARY_W - 2));

   logic [10:0]         nxt_rem_q;
   logic [10:0]         lim_q;
   xfer_pkg::byte_off_t end_off_q;
   axi_pkg::axi_addr_t  nxt_addr_q;

   logic [8:0]          span;
   xfer_pkg::byte_off_t end_off;
   xfer_pkg::byte_off_t src_end;
   axi_pkg::axi_addr_t  src_addr;
   logic [10:0]         src_rem;
   logic [10:0]         src_lim;
   logic [10:0]         to_bound;
   logic [10:0]         beats;
   logic                last;

   function automatic axi_pkg::axi_strb_t tail_strb(xfer_pkg::byte_off_t off);
      if (off == 2'd0) begin
         tail_strb = 4'hF;
      end else begin
         tail_strb = ~(4'hF << off);   // Bytes below end offset
      end
   endfunction

   always_comb begin
      span = {1'b0, len_i} + {7'b0, addr_i[1:0]} + 9'd3;
      end_off = addr_i[1:0] + len_i[1:0];

      if (b.start) begin
         src_addr = {addr_i[31:2], 2'b00};
         src_rem = {4'b0, span[8:2]};   // ceil((O + L) / 4)
         src_end = end_off;
         if (limit_i == '0 || {3'b0, limit_i} > MAX_BEATS) begin
            src_lim = MAX_BEATS;
         end else begin
            src_lim = {3'b0, limit_i};
         end
      end else begin
         src_addr = nxt_addr_q;
         src_rem = nxt_rem_q;
         src_end = end_off_q;
         src_lim = lim_q;
      end

      // Beats left in this 4 KB page
      to_bound = PAGE_BEATS - {1'b0, src_addr[axi_pkg::AXI_BOUNDARY_W-1:2]};

      beats = src_lim;
      if (to_bound < beats) beats = to_bound;
      if (src_rem < beats) beats = src_rem;

      last = src_rem == beats;
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         nxt_rem_q <= '0;
         lim_q <= MAX_BEATS;
         end_off_q <= '0;
         b.last_burst <= 1'b0;
      end else if (b.start || b.next) begin
         nxt_rem_q <= src_rem - beats;
         b.last_burst <= last;
         if (b.start) begin
            lim_q <= src_lim;   // Limit holds for the whole transfer
            end_off_q <= end_off;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (b.start || b.next) begin
         nxt_addr_q <= src_addr + {19'b0, beats, 2'b00};
         b.addr <= src_addr;
         b.len <= axi_pkg::axi_len_t'(beats - 11'd1);
         b.first_strb <= b.start ? (4'hF << addr_i[1:0]) : 4'hF;
         b.last_strb <= last ? tail_strb(src_end) : 4'hF;
      end
   end

   // Last beat of each planned burst stays in the page of its first beat
   a_no_4k_cross: assert property (@(posedge clk_i) disable iff (rst_i)
      $past(b.start || b.next) |->
         ({1'b0, b.addr[axi_pkg::AXI_BOUNDARY_W-1:2]} + {3'b0, b.len}) < PAGE_BEATS);

endmodule

/* rtl/byte_realigner.sv */
`timescale 1ns/1ps

module byte_realigner (
   input  logic                clk_i,
   input  logic                rst_i,
   input  xfer_pkg::byte_off_t offset_i,
   input  axi_pkg::axi_data_t  word_i,
   input  logic                take_i,
   output axi_pkg::axi_data_t  beat_o
);

   axi_pkg::axi_data_t prev_q;   // Last accepted client word

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         prev_q <= '0;
      end else if (take_i) begin
         prev_q <= word_i;
      end
   end

   // Low lanes take the spill-over from the previous word
   always_comb begin
      case (offset_i)
         2'd0: beat_o = word_i;
         2'd1: beat_o = {word_i[23:0], prev_q[31:24]};
         2'd2: beat_o = {word_i[15:0], prev_q[31:16]};
         default: beat_o = {word_i[7:0], prev_q[31:8]};
      endcase
   end

endmodule

/* rtl/axi_write_engine.sv */
`timescale 1ns/1ps

module axi_write_engine (
   input  logic                clk_i,
   input  logic                rst_i,
   burst_if.engine             b,
   input  logic                m_wvalid_i,
   input  xfer_pkg::byte_len_t m_wlen_i,
   input  axi_pkg::axi_addr_t  m_waddr_i,
   output logic                m_wready_o,
   output logic                m_wlast_o,
   output logic                take_o,
   output xfer_pkg::byte_off_t offset_o,
   output axi_pkg::axi_addr_t  axi_awaddr_o,
   output axi_pkg::axi_len_t   axi_awlen_o,
   output logic [2:0]          axi_awsize_o,
   output logic [1:0]          axi_awburst_o,
   output logic [3:0]          axi_awcache_o,
   output logic [2:0]          axi_awprot_o,
   output logic                axi_awvalid_o,
   input  logic                axi_awready_i,
   output axi_pkg::axi_strb_t  axi_wstrb_o,
   output logic                axi_wlast_o,
   output logic                axi_wvalid_o,
   input  logic                axi_wready_i,
   input  axi_pkg::axi_resp_t  axi_bresp_i,
   input  logic                axi_bvalid_i,
   output logic                axi_bready_o,
   input  xfer_pkg::cfg_data_t cfg_attr_i,
   output logic                done_o,
   output logic                err_o
);

   typedef enum logic [1:0] {IDLE, PLAN, ADDR, DATA} state_t;

   state_t             state_q;
   axi_pkg::axi_len_t  beat_q;    // Beat within burst
   logic [6:0]         words_q;   // Client words still to take
   logic [3:0]         cache_q;
   logic [2:0]         prot_q;
   logic [8:0]         word_sum;
   logic               beat_hs;
   axi_pkg::axi_strb_t head;
   axi_pkg::axi_strb_t tail;

   assign word_sum = {1'b0, m_wlen_i} + 9'd3;
   assign beat_hs = axi_wvalid_o && axi_wready_i;

   assign b.start = state_q == IDLE && m_wvalid_i;
   assign b.next = beat_hs && axi_wlast_o && !b.last_burst;

   // Flush beat goes out once the client words are used up
   assign axi_wvalid_o = state_q == DATA && (words_q == '0 || m_wvalid_i);
   assign m_wready_o = state_q == DATA && words_q != '0 && axi_wready_i;
   assign take_o = m_wvalid_i && m_wready_o;

   assign axi_wlast_o = state_q == DATA && beat_q == axi_awlen_o;
   assign m_wlast_o = beat_hs && axi_wlast_o && b.last_burst;

   assign head = (beat_q == '0) ? b.first_strb : 4'hF;
   assign tail = axi_wlast_o ? b.last_strb : 4'hF;
   assign axi_wstrb_o = head & tail;   // Single beat gets both edges

   assign axi_awsize_o = axi_pkg::AXI_SIZE_4B;
   assign axi_awburst_o = axi_pkg::AXI_BURST_INCR;
   assign axi_awcache_o = cache_q;
   assign axi_awprot_o = prot_q;

   assign axi_bready_o = 1'b1;
   assign done_o = m_wlast_o;
   assign err_o = axi_bvalid_i && axi_bready_o && axi_bresp_i != axi_pkg::AXI_RESP_OKAY;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= IDLE;
         axi_awvalid_o <= 1'b0;
         beat_q <= '0;
         words_q <= '0;
         offset_o <= '0;
         cache_q <= xfer_pkg::CFG_ATTR_RESET[3:0];
         prot_q <= xfer_pkg::CFG_ATTR_RESET[6:4];
      end else begin
         if (take_o) words_q <= words_q - 7'd1;
         case (state_q)
            IDLE: begin
               if (m_wvalid_i) begin
                  words_q <= word_sum[8:2];
                  offset_o <= m_waddr_i[1:0];
                  cache_q <= cfg_attr_i[3:0];   // Attributes fixed per transfer
                  prot_q <= cfg_attr_i[6:4];
                  state_q <= PLAN;
               end
            end
            PLAN: begin
               axi_awvalid_o <= 1'b1;
               beat_q <= '0;
               state_q <= ADDR;
            end
            ADDR: begin
               if (axi_awready_i) begin
                  axi_awvalid_o <= 1'b0;
                  state_q <= DATA;
               end
            end
            default: begin
               if (beat_hs) begin
                  beat_q <= beat_q + 8'd1;
                  if (axi_wlast_o) state_q <= b.last_burst ? IDLE : PLAN;
               end
            end
         endcase
      end
   end

   // Burst is loaded from the planner one cycle before AWVALID
   always_ff @(posedge clk_i) begin
      if (state_q == PLAN) begin
         axi_awaddr_o <= b.addr;
         axi_awlen_o <= b.len;
      end
   end

   a_aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_awvalid_o && !axi_awready_i |=>
         axi_awvalid_o && $stable(axi_awaddr_o) && $stable(axi_awlen_o));

   // WLAST of the final burst lines up with the end of the client data
   a_wlast_end: assert property (@(posedge clk_i) disable iff (rst_i)
      beat_hs && axi_wlast_o && b.last_burst |->
         words_q == '0 || (words_q == 7'd1 && take_o));

endmodule

/* rtl/writer_cfg_regs.sv */
`timescale 1ns/1ps

module writer_cfg_regs #(
   parameter int MAX_BEATS_LOG2 = 4
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                cfg_we_i,
   input  xfer_pkg::cfg_addr_t cfg_addr_i,
   input  xfer_pkg::cfg_data_t cfg_wdata_i,
   output xfer_pkg::cfg_data_t cfg_rdata_o,
   output axi_pkg::axi_len_t   limit_o,
   output xfer_pkg::cfg_data_t attr_o,
   input  logic                done_i,
   input  logic                err_i
);

   localparam xfer_pkg::cfg_data_t MAX_BEATS = xfer_pkg::cfg_data_t'(1 << MAX_BEATS_LOG2);

   xfer_pkg::cfg_data_t limit_q;
   xfer_pkg::cfg_data_t attr_q;
   xfer_pkg::cfg_data_t err_cnt_q;
   xfer_pkg::cfg_data_t done_cnt_q;

   function automatic xfer_pkg::cfg_data_t clamp_limit(xfer_pkg::cfg_data_t v);
      if (v == '0) begin
         clamp_limit = 16'd1;
      end else if (v > MAX_BEATS) begin
         clamp_limit = MAX_BEATS;
      end else begin
         clamp_limit = v;
      end
   endfunction

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         limit_q <= MAX_BEATS;
         attr_q <= xfer_pkg::CFG_ATTR_RESET;
         err_cnt_q <= '0;
         done_cnt_q <= '0;
      end else begin
         if (cfg_we_i && cfg_addr_i == xfer_pkg::CFG_BURST_LIMIT) begin
            limit_q <= clamp_limit(cfg_wdata_i);
         end
         if (cfg_we_i && cfg_addr_i == xfer_pkg::CFG_ATTR) begin
            attr_q <= cfg_wdata_i & 16'h007F;
         end
         if (cfg_we_i && cfg_addr_i == xfer_pkg::CFG_ERR_COUNT) begin
            err_cnt_q <= '0;
         end else if (err_i && err_cnt_q != 16'hFFFF) begin
            err_cnt_q <= err_cnt_q + 16'd1;   // Saturates
         end
         if (cfg_we_i && cfg_addr_i == xfer_pkg::CFG_DONE_COUNT) begin
            done_cnt_q <= '0;
         end else if (done_i && done_cnt_q != 16'hFFFF) begin
            done_cnt_q <= done_cnt_q + 16'd1;
         end
      end
   end

   always_comb begin
      case (cfg_addr_i)
         xfer_pkg::CFG_BURST_LIMIT: cfg_rdata_o = limit_q;
         xfer_pkg::CFG_ATTR: cfg_rdata_o = attr_q;
         xfer_pkg::CFG_ERR_COUNT: cfg_rdata_o = err_cnt_q;
         default: cfg_rdata_o = done_cnt_q;
      endcase
   end

   assign limit_o = axi_pkg::axi_len_t'(limit_q);   // 256 wraps to 0
   assign attr_o = attr_q;

endmodule

/* rtl/simple_axi_writer.sv */
`timescale 1ns/1ps

module simple_axi_writer #(
   parameter int MAX_BEATS_LOG2 = 4
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                m_wvalid_i,
   input  axi_pkg::axi_addr_t  m_waddr_i,
   input  xfer_pkg::byte_len_t m_wlen_i,
   input  axi_pkg::axi_data_t  m_wdata_i,
   output logic                m_wready_o,
   output logic                m_wlast_o,
   input  logic                cfg_we_i,
   input  xfer_pkg::cfg_addr_t cfg_addr_i,
   input  xfer_pkg::cfg_data_t cfg_wdata_i,
   output xfer_pkg::cfg_data_t cfg_rdata_o,
   output axi_pkg::axi_addr_t  axi_awaddr_o,
   output axi_pkg::axi_len_t   axi_awlen_o,
   output logic [2:0]          axi_awsize_o,
   output logic [1:0]          axi_awburst_o,
   output logic [3:0]          axi_awcache_o,
   output logic [2:0]          axi_awprot_o,
   output logic                axi_awvalid_o,
   input  logic                axi_awready_i,
   output axi_pkg::axi_data_t  axi_wdata_o,
   output axi_pkg::axi_strb_t  axi_wstrb_o,
   output logic                axi_wlast_o,
   output logic                axi_wvalid_o,
   input  logic                axi_wready_i,
   input  axi_pkg::axi_resp_t  axi_bresp_i,
   input  logic                axi_bvalid_i,
   output logic                axi_bready_o
);

   axi_pkg::axi_len_t   limit;
   xfer_pkg::cfg_data_t attr;
   xfer_pkg::byte_off_t offset;
   logic                take;
   logic                done;
   logic                err;

   burst_if burst ();

   burst_planner #(
      .MAX_BEATS_LOG2(MAX_BEATS_LOG2)
   ) u_planner (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .addr_i (m_waddr_i),
      .len_i  (m_wlen_i),
      .limit_i(limit),
      .b      (burst.planner)
   );

   byte_realigner u_realigner (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .offset_i(offset),
      .word_i  (m_wdata_i),
      .take_i  (take),
      .beat_o  (axi_wdata_o)
   );

   axi_write_engine u_engine (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .b            (burst.engine),
      .m_wvalid_i   (m_wvalid_i),
      .m_wlen_i     (m_wlen_i),
      .m_waddr_i    (m_waddr_i),
      .m_wready_o   (m_wready_o),
      .m_wlast_o    (m_wlast_o),
      .take_o       (take),
      .offset_o     (offset),
      .axi_awaddr_o (axi_awaddr_o),
      .axi_awlen_o  (axi_awlen_o),
      .axi_awsize_o (axi_awsize_o),
      .axi_awburst_o(axi_awburst_o),
      .axi_awcache_o(axi_awcache_o),
      .axi_awprot_o (axi_awprot_o),
      .axi_awvalid_o(axi_awvalid_o),
      .axi_awready_i(axi_awready_i),
      .axi_wstrb_o  (axi_wstrb_o),
      .axi_wlast_o  (axi_wlast_o),
      .axi_wvalid_o (axi_wvalid_o),
      .axi_wready_i (axi_wready_i),
      .axi_bresp_i  (axi_bresp_i),
      .axi_bvalid_i (axi_bvalid_i),
      .axi_bready_o (axi_bready_o),
      .cfg_attr_i   (attr),
      .done_o       (done),
      .err_o        (err)
   );

   writer_cfg_regs #(
      .MAX_BEATS_LOG2(MAX_BEATS_LOG2)
   ) u_cfg (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cfg_we_i   (cfg_we_i),
      .cfg_addr_i (cfg_addr_i),
      .cfg_wdata_i(cfg_wdata_i),
      .cfg_rdata_o(cfg_rdata_o),
      .limit_o    (limit),
      .attr_o     (attr),
      .done_i     (done),
      .err_i      (err)
   );

endmodule

/* test/axi_write_checker.sv */
`timescale 1ns/1ps

module axi_write_checker (
   input  logic          clk_i,
   input  logic          rst_i,
   input  logic          m_wvalid_i,
   input  logic          m_wlast_i,
   input  logic [31:0]   axi_awaddr_i,
   input  logic [7:0]    axi_awlen_i,
   input  logic [2:0]    axi_awsize_i,
   input  logic [1:0]    axi_awburst_i,
   input  logic [3:0]    axi_awcache_i,
   input  logic [2:0]    axi_awprot_i,
   input  logic          axi_awvalid_i,
   input  logic          axi_awready_i,
   input  logic [31:0]   axi_wdata_i,
   input  logic [3:0]    axi_wstrb_i,
   input  logic          axi_wlast_i,
   input  logic          axi_wvalid_i,
   input  logic          axi_wready_i,
   input  logic          axi_bready_i,
   input  logic [31:0]   exp_addr_i,
   input  logic [7:0]    exp_len_i,
   input  logic [8:0]    exp_limit_i,
   input  logic [6:0]    exp_attr_i,
   input  logic [2039:0] exp_bytes_i,
   output int            err_count_o
);

   logic [7:0]  mem [logic [31:0]];   // Bytes written in the current transfer
   logic [31:0] bur_addr;
   logic [7:0]  bur_len;
   logic [7:0]  beat;
   int          xfer_beats;
   int          since;                // Cycles since request or burst end
   logic        armed;
   logic        req_q, awv_q, awr_q, wv_q, wr_q;
   logic [31:0] awaddr_q;
   logic [7:0]  awlen_q;

   task automatic flag_mismatch(input string sig, input longint got, input longint exp);
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
      err_count_o++;
   endtask

   initial err_count_o = 0;

   always @(posedge clk_i) begin : watch
      logic [31:0] a;
      int          k;
      if (rst_i) begin
         armed = 1'b0;
         req_q = 1'b0;
         awv_q = 1'b0;
         wv_q = 1'b0;
      end else begin
         if (m_wvalid_i && !req_q) begin
            mem.delete();
            xfer_beats = 0;
            armed = 1'b1;
            since = 0;
         end else if (armed) begin
            since++;
         end
         if (axi_awvalid_i && armed) begin
            if (since != 2) flag_mismatch("AWVALID delay", since, 2);
            armed = 1'b0;
         end
         if (awv_q && !awr_q) begin   // Held AW must not change
            if (!axi_awvalid_i) flag_mismatch("axi_awvalid_o", 0, 1);
            if (axi_awaddr_i != awaddr_q) flag_mismatch("axi_awaddr_o", axi_awaddr_i, awaddr_q);
            if (axi_awlen_i != awlen_q) flag_mismatch("axi_awlen_o", axi_awlen_i, awlen_q);
         end
         if (wv_q && !wr_q && !axi_wvalid_i) flag_mismatch("axi_wvalid_o", 0, 1);
         if (!axi_bready_i) flag_mismatch("axi_bready_o", axi_bready_i, 1);   // Always ready
         if (axi_awvalid_i && axi_awready_i) begin
            if (axi_awburst_i != 2'b01) flag_mismatch("axi_awburst_o", axi_awburst_i, 1);
            if (axi_awsize_i != 3'd2) flag_mismatch("axi_awsize_o", axi_awsize_i, 2);
            if ({axi_awprot_i, axi_awcache_i} != exp_attr_i)
               flag_mismatch("axi_awprot_o/axi_awcache_o", {axi_awprot_i, axi_awcache_i},
                             exp_attr_i);
            if (axi_awlen_i + 9'd1 > exp_limit_i)
               flag_mismatch("axi_awlen_o + 1", axi_awlen_i + 9'd1, exp_limit_i);
            if ({1'b0, axi_awaddr_i[11:2]} + axi_awlen_i >= 11'd1024) begin
               $display("Burst at %h crosses a 4 KB boundary (time %0t ns)",
                        axi_awaddr_i, $time);
               err_count_o++;
            end
            bur_addr = axi_awaddr_i;
            bur_len = axi_awlen_i;
            beat = '0;
         end
         if (axi_wvalid_i && axi_wready_i) begin
            if (axi_wlast_i != (beat == bur_len))
               flag_mismatch("axi_wlast_o", axi_wlast_i, beat == bur_len);
            for (k = 0; k < 4; k++) begin
               a = bur_addr + {22'b0, beat, 2'b00} + k;
               if (axi_wstrb_i[k]) begin
                  if (a < exp_addr_i || a >= exp_addr_i + exp_len_i) begin
                     $display("Byte written outside the transfer at %h (time %0t ns)",
                              a, $time);
                     err_count_o++;
                  end else begin
                     mem[a] = axi_wdata_i[k*8 +: 8];
                  end
               end
            end
            beat++;
            xfer_beats++;
            if (axi_wlast_i && !m_wlast_i) begin
               armed = 1'b1;
               since = 0;
            end
         end
         if (m_wlast_i) begin
            if (xfer_beats != (exp_addr_i[1:0] + exp_len_i + 3) / 4)
               flag_mismatch("beats per transfer", xfer_beats,
                             (exp_addr_i[1:0] + exp_len_i + 3) / 4);
            for (k = 0; k < exp_len_i; k++) begin
               a = exp_addr_i + k;
               if (!mem.exists(a)) begin
                  $display("Byte at %h was never written (time %0t ns)", a, $time);
                  err_count_o++;
               end else if (mem[a] != exp_bytes_i[k*8 +: 8]) begin
                  flag_mismatch($sformatf("memory[%h]", a), mem[a], exp_bytes_i[k*8 +: 8]);
               end
            end
         end
         req_q = m_wvalid_i;
         awv_q = axi_awvalid_i;
         awr_q = axi_awready_i;
         awaddr_q = axi_awaddr_i;
         awlen_q = axi_awlen_i;
         wv_q = axi_wvalid_i;
         wr_q = axi_wready_i;
      end
   end

endmodule

/* test/tb_simple_axi_writer.sv */
`timescale 1ns/1ps

module tb_simple_axi_writer;

   localparam int MAX_BEATS_LOG2 = 4;
   localparam int N_XFER = 8;

   // Address, length, beat limit, stall density (0 to 6), attributes
   logic [31:0] tbl_addr [N_XFER] = '{32'h1000, 32'h1001, 32'h0FFA, 32'h2003,
                                      32'h2002, 32'h3FF1, 32'h3100, 32'h4FFF};
   logic [7:0]  tbl_len [N_XFER] = '{8'd16, 8'd7, 8'd40, 8'd1, 8'd255, 8'd100, 8'd33, 8'd200};
   logic [15:0] tbl_limit [N_XFER] = '{16'd16, 16'd4, 16'd16, 16'd8, 16'd0, 16'd20, 16'd3, 16'd16};
   logic [2:0]  tbl_stall [N_XFER] = '{3'd0, 3'd3, 3'd2, 3'd1, 3'd4, 3'd5, 3'd6, 3'd3};
   logic [6:0]  tbl_attr [N_XFER] = '{7'h22, 7'h22, 7'h35, 7'h35, 7'h7F, 7'h10, 7'h22, 7'h44};

   logic clk_i, rst_i;
   logic m_wvalid_i, m_wready_o, m_wlast_o;
   logic [31:0] m_waddr_i, m_wdata_i;
   logic [7:0] m_wlen_i;
   logic cfg_we_i;
   logic [1:0] cfg_addr_i;
   logic [15:0] cfg_wdata_i, cfg_rdata_o;
   logic [31:0] axi_awaddr_o, axi_wdata_o;
   logic [7:0] axi_awlen_o;
   logic [2:0] axi_awsize_o, axi_awprot_o;
   logic [1:0] axi_awburst_o, axi_bresp_i;
   logic [3:0] axi_awcache_o, axi_wstrb_o;
   logic axi_awvalid_o, axi_awready_i, axi_wlast_o, axi_wvalid_o, axi_wready_i;
   logic axi_bvalid_i, axi_bready_o;

   logic [31:0] exp_addr;
   logic [7:0] exp_len;
   logic [8:0] exp_limit;
   logic [6:0] exp_attr;
   logic [2039:0] exp_bytes;
   int chk_errors, tb_errors, slverr_sent;
   int unsigned data_seed, stall_seed;
   logic [2:0] stall_lvl;
   logic b_pend, b_err;
   logic [31:0] aw_addr;

   simple_axi_writer #(.MAX_BEATS_LOG2(MAX_BEATS_LOG2)) UUT (.*);

   axi_write_checker chk (
      .clk_i(clk_i), .rst_i(rst_i), .m_wvalid_i(m_wvalid_i), .m_wlast_i(m_wlast_o),
      .axi_awaddr_i(axi_awaddr_o), .axi_awlen_i(axi_awlen_o), .axi_awsize_i(axi_awsize_o),
      .axi_awburst_i(axi_awburst_o), .axi_awcache_i(axi_awcache_o),
      .axi_awprot_i(axi_awprot_o), .axi_awvalid_i(axi_awvalid_o),
      .axi_awready_i(axi_awready_i), .axi_wdata_i(axi_wdata_o), .axi_wstrb_i(axi_wstrb_o),
      .axi_wlast_i(axi_wlast_o), .axi_wvalid_i(axi_wvalid_o), .axi_wready_i(axi_wready_i),
      .axi_bready_i(axi_bready_o),
      .exp_addr_i(exp_addr), .exp_len_i(exp_len), .exp_limit_i(exp_limit),
      .exp_attr_i(exp_attr), .exp_bytes_i(exp_bytes), .err_count_o(chk_errors)
   );

   function automatic int unsigned lcg_next(input int unsigned s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [8:0] clamped_limit(input logic [15:0] v);
      if (v == 0) return 9'd1;
      if (v > (1 << MAX_BEATS_LOG2)) return 9'(1 << MAX_BEATS_LOG2);
      return v[8:0];
   endfunction

   task automatic check_value(input string name, input longint got, input longint exp);
      if (got != exp) begin
         $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         tb_errors++;
      end
   endtask

   task automatic cfg_write(input logic [1:0] a, input logic [15:0] d);
      @(negedge clk_i);
      cfg_we_i = 1'b1;
      cfg_addr_i = a;
      cfg_wdata_i = d;
      @(negedge clk_i);
      cfg_we_i = 1'b0;
   endtask

   task automatic cfg_check(input logic [1:0] a, input logic [15:0] exp, input string name);
      @(negedge clk_i);
      cfg_addr_i = a;
      #1;
      check_value(name, cfg_rdata_o, exp);
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $finish;
   endtask

   task automatic run_transfer(input int n);
      logic [31:0] words [65];
      int i, widx, cycles;
      logic fin;
      cfg_write(2'd0, tbl_limit[n]);
      cfg_check(2'd0, 16'(clamped_limit(tbl_limit[n])), "CFG_BURST_LIMIT");
      cfg_write(2'd1, {9'b0, tbl_attr[n]});
      exp_limit = clamped_limit(tbl_limit[n]);
      exp_attr = tbl_attr[n];
      exp_bytes = '0;
      for (i = 0; i < 65; i++) words[i] = '0;
      for (i = 0; i < tbl_len[n]; i++) begin
         data_seed = lcg_next(data_seed);
         exp_bytes[i*8 +: 8] = data_seed[23:16];
         words[i/4][(i%4)*8 +: 8] = data_seed[23:16];
      end
      exp_addr = tbl_addr[n];
      exp_len = tbl_len[n];
      stall_lvl = tbl_stall[n];
      widx = 0;
      cycles = 0;
      fin = 1'b0;
      @(negedge clk_i);
      m_waddr_i = tbl_addr[n];
      m_wlen_i = tbl_len[n];
      m_wvalid_i = 1'b1;
      while (!fin) begin
         m_wdata_i = words[widx];
         #2;
         fin = m_wlast_o;
         if (m_wready_o && widx < 64) widx++;   // Word taken on the coming edge
         @(negedge clk_i);
         cycles++;
         if (cycles > 5000) abort_run($sformatf("Timeout in transfer %0d", n));
      end
      m_wvalid_i = 1'b0;
   endtask

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // AXI slave with random READY stalls, SLVERR for bursts in 0x3000 to 0x3FFF
   always @(negedge clk_i) begin
      if (!rst_i) begin
         axi_bvalid_i = b_pend;
         axi_bresp_i = b_err ? 2'b10 : 2'b00;
         if (b_pend && b_err) slverr_sent++;
         b_pend = 1'b0;
         stall_seed = lcg_next(stall_seed);
         axi_awready_i = stall_seed[18:16] >= stall_lvl;
         stall_seed = lcg_next(stall_seed);
         axi_wready_i = stall_seed[18:16] >= stall_lvl;
         #1;
         if (axi_awvalid_o && axi_awready_i) aw_addr = axi_awaddr_o;
         if (axi_wvalid_o && axi_wready_i && axi_wlast_o) begin
            b_pend = 1'b1;
            b_err = aw_addr >= 32'h3000 && aw_addr < 32'h4000;
         end
      end
   end

   initial begin
      int n, wait_cnt;
      rst_i = 1'b1;
      m_wvalid_i = 1'b0;
      m_waddr_i = '0;
      m_wlen_i = '0;
      m_wdata_i = '0;
      cfg_we_i = 1'b0;
      cfg_addr_i = '0;
      cfg_wdata_i = '0;
      axi_awready_i = 1'b0;
      axi_wready_i = 1'b0;
      axi_bvalid_i = 1'b0;
      axi_bresp_i = 2'b00;
      exp_addr = '0;
      exp_len = '0;
      exp_limit = 9'd16;
      exp_attr = 7'h22;
      exp_bytes = '0;
      tb_errors = 0;
      slverr_sent = 0;
      data_seed = 99375;
      stall_seed = 99375;
      stall_lvl = '0;
      b_pend = 1'b0;
      b_err = 1'b0;
      aw_addr = '0;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      #1;
      check_value("axi_awvalid_o", axi_awvalid_o, 0);
      check_value("axi_wvalid_o", axi_wvalid_o, 0);
      check_value("axi_wlast_o", axi_wlast_o, 0);
      check_value("m_wready_o", m_wready_o, 0);
      check_value("m_wlast_o", m_wlast_o, 0);
      for (n = 0; n < N_XFER; n++) run_transfer(n);
      wait_cnt = 0;
      while (b_pend || axi_bvalid_i) begin   // Last B response still on its way
         @(negedge clk_i);
         wait_cnt++;
         if (wait_cnt > 20) abort_run("Timeout waiting for the last write response");
      end
      cfg_check(2'd3, 16'(N_XFER), "CFG_DONE_COUNT");
      cfg_check(2'd2, 16'(slverr_sent), "CFG_ERR_COUNT");
      if (slverr_sent == 0) begin
         $display("The slave never answered with SLVERR");
         tb_errors++;
      end
      cfg_write(2'd3, 16'hFFFF);
      cfg_check(2'd3, 16'd0, "CFG_DONE_COUNT after clear");
      $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
      if (chk_errors + tb_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* build.f */
rtl/axi_pkg.sv
rtl/xfer_pkg.sv
rtl/burst_if.sv
rtl/burst_planner.sv
rtl/byte_realigner.sv
rtl/axi_write_engine.sv
rtl/writer_cfg_regs.sv
rtl/simple_axi_writer.sv
test/axi_write_checker.sv
test/tb_simple_axi_writer.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_simple_axi_writer -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/Vtb_simple_axi_writer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
   exit 0
fi
exit 1
